//--- Makefile
TOP := tb_blit_ctrl
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- blit_addr_update.sv
// A1 and A2 pointer registers, loaded from their bases and stepped between rows
`timescale 1ns/1ps
`default_nettype none

module blit_addr_update import blit_pkg::*; (
	input  wire logic sys_clk,
	input  wire logic resetl,
	input  wire logic a1_load,
	input  wire logic a2_load,
	input  wire ptr_t a1_base,
	input  wire ptr_t a1_step,
	input  wire ptr_t a1_fstep,
	input  wire ptr_t a2_base,
	input  wire ptr_t a2_step,
	input  wire logic a1fupdate,
	input  wire logic a1update,
	input  wire logic a2update,
	output ptr_t      a1_ptr,
	output ptr_t      a2_ptr
);

	// Next pointer values
	ptr_t a1_nxt;
	ptr_t a2_nxt;

	always_comb begin
		a1_nxt = a1_ptr;
		// Base write takes priority over any step
		if (a1_load)
			a1_nxt = a1_base;
		else if (a1fupdate)
			a1_nxt = a1_ptr + a1_fstep;
		else if (a1update)
			a1_nxt = a1_ptr + a1_step;
	end

	always_comb begin
		a2_nxt = a2_ptr;
		if (a2_load)
			a2_nxt = a2_base;
		else if (a2update)
			a2_nxt = a2_ptr + a2_step;
	end

	// Sums wrap at the pointer width
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			a1_ptr <= '0;
			a2_ptr <= '0;
		end else begin
			a1_ptr <= a1_nxt;
			a2_ptr <= a2_nxt;
		end
	end

endmodule

`default_nettype wire

//--- blit_cmd_if.sv
// Decoded command fields passed from the register block to the outer sequencer
`timescale 1ns/1ps
`default_nettype none

interface blit_cmd_if;

	// One cycle start pulse
	logic go;

	// Row update selects
	logic upda1f;
	logic upda1;
	logic upda2;

	// High priority bus request select
	logic bushi;

	// Register block drives every field
	modport regs (
		output go,
		output upda1f,
		output upda1,
		output upda2,
		output bushi
	);

	// Sequencer only samples them
	modport seq (
		input go,
		input upda1f,
		input upda1,
		input upda2,
		input bushi
	);

endinterface

`default_nettype wire

//--- blit_ctrl_top.sv
// Blitter control top level, joins register decode, sequencer, pixel counter and pointer unit
`timescale 1ns/1ps
`default_nettype none

module blit_ctrl_top import blit_pkg::*; (
	input  wire logic      sys_clk,
	input  wire logic      resetl,
	input  wire logic      reg_wr,
	input  wire reg_addr_t reg_addr,
	input  wire reg_data_t reg_wdata,
	input  wire logic      stat_rd,
	output stat_t          stat_data,
	input  wire logic      bus_active,
	input  wire logic      stopped,
	output logic [1:0]     blit_breq,
	output logic           blit_int,
	output ptr_t           a1_ptr,
	output ptr_t           a2_ptr
);

	blit_cmd_if cmd_bus ();

	// Register block to sequencer, pixel counter and pointer unit
	cnt_t outer_count;
	cnt_t inner_count;
	logic count_ld;
	ptr_t a1_base;
	ptr_t a1_step;
	ptr_t a1_fstep;
	ptr_t a2_base;
	ptr_t a2_step;
	logic a1_load;
	logic a2_load;

	// Sequencer handshakes
	logic instart;
	logic indone;
	logic a1fupdate;
	logic a1update;
	logic a2update;

	blit_regs u_regs (
		.sys_clk(sys_clk), .resetl(resetl), .reg_wr(reg_wr), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .cmd(cmd_bus.regs), .outer_count(outer_count),
		.inner_count(inner_count), .count_ld(count_ld), .a1_base(a1_base),
		.a1_step(a1_step), .a1_fstep(a1_fstep), .a2_base(a2_base), .a2_step(a2_step),
		.a1_load(a1_load), .a2_load(a2_load)
	);

	blit_outer u_outer (
		.sys_clk(sys_clk), .resetl(resetl), .cmd(cmd_bus.seq), .outer_count(outer_count),
		.count_ld(count_ld), .indone(indone), .bus_active(bus_active), .stopped(stopped),
		.stat_rd(stat_rd), .instart(instart), .a1fupdate(a1fupdate), .a1update(a1update),
		.a2update(a2update), .blit_int(blit_int), .blit_breq(blit_breq),
		.stat_data(stat_data)
	);

	blit_inner u_inner (
		.sys_clk(sys_clk), .resetl(resetl), .instart(instart),
		.inner_count(inner_count), .indone(indone)
	);

	blit_addr_update u_addr (
		.sys_clk(sys_clk), .resetl(resetl), .a1_load(a1_load), .a2_load(a2_load),
		.a1_base(a1_base), .a1_step(a1_step), .a1_fstep(a1_fstep), .a2_base(a2_base),
		.a2_step(a2_step), .a1fupdate(a1fupdate), .a1update(a1update),
		.a2update(a2update), .a1_ptr(a1_ptr), .a2_ptr(a2_ptr)
	);

endmodule

`default_nettype wire

//--- blit_inner.sv
// Inner loop pixel counter, loaded at each row start, flags the last pixel of the row
`timescale 1ns/1ps
`default_nettype none

module blit_inner import blit_pkg::*; (
	input  wire logic sys_clk,
	input  wire logic resetl,
	input  wire logic instart,
	input  wire cnt_t inner_count,
	output logic      indone
);

	// Remaining pixels including the current one
	cnt_t icount;
	logic running;

	// Last pixel when one remains
	assign indone = running && (icount == cnt_t'(1));

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			icount  <= '0;
			running <= 1'b0;
		end else begin
			if (instart) begin
				// Reload wins even on the last pixel of the previous row
				icount  <= inner_count;
				running <= 1'b1;
			end else if (indone) begin
				// Hold here until the sequencer starts another row
				running <= 1'b0;
			end else if (running) begin
				icount <= icount - 1'b1;
			end
		end
	end

	// Row end only inside a row that was started or was already counting
	indone_in_row: assert property (@(posedge sys_clk) disable iff (!resetl)
		indone |-> running && $past(instart || running))
		else $error("indone outside a running row");

endmodule

`default_nettype wire

//--- blit_outer.sv
// Outer loop sequencer: row counting, update chain between rows, status, bus request, interrupt
`timescale 1ns/1ps
`default_nettype none

module blit_outer import blit_pkg::*; (
	input  wire logic  sys_clk,
	input  wire logic  resetl,
	blit_cmd_if.seq    cmd,
	input  wire cnt_t  outer_count,
	input  wire logic  count_ld,
	input  wire logic  indone,
	input  wire logic  bus_active,
	input  wire logic  stopped,
	input  wire logic  stat_rd,
	output logic       instart,
	output logic       a1fupdate,
	output logic       a1update,
	output logic       a2update,
	output logic       blit_int,
	output logic [1:0] blit_breq,
	output stat_t      stat_data
);

	outer_state_t state;
	outer_state_t state_nxt;
	cnt_t         ocount;
	logic         outer0;
	logic         no_upd;
	logic         idle_free;
	logic         idled;
	logic         breq_on;
	stat_t        stat_word;

	assign outer0 = (ocount == '0);
	assign no_upd = !cmd.upda1f && !cmd.upda1 && !cmd.upda2;

	// Update strobes are the update states themselves
	assign a1fupdate = (state == OST_A1F);
	assign a1update  = (state == OST_A1);
	assign a2update  = (state == OST_A2);

	// Row start from idle, back to back rows, or last update of the chain
	assign instart = ((state == OST_IDLE) && cmd.go) ||
		((state == OST_INNER) && indone && !outer0 && no_upd) ||
		((state == OST_A1) && !cmd.upda2) ||
		(state == OST_A2);

	always_comb begin
		state_nxt = state;
		case (state)
			OST_IDLE: begin
				if (cmd.go)
					state_nxt = OST_INNER;
			end
			OST_INNER: begin
				// Pick the first selected update, else stay for the next row
				if (indone) begin
					if (outer0)
						state_nxt = OST_IDLE;
					else if (cmd.upda1f)
						state_nxt = OST_A1F;
					else if (cmd.upda1)
						state_nxt = OST_A1;
					else if (cmd.upda2)
						state_nxt = OST_A2;
				end
			end
			// Fractional step is always paired with the integer step
			OST_A1F: state_nxt = OST_A1;
			OST_A1:  state_nxt = cmd.upda2 ? OST_A2 : OST_INNER;
			OST_A2:  state_nxt = OST_INNER;
			default: state_nxt = OST_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			state  <= OST_IDLE;
			ocount <= '0;
			idled  <= 1'b1;
		end else begin
			state <= state_nxt;
			// Count write wins over a row start
			if (count_ld)
				ocount <= outer_count;
			else if (instart)
				ocount <= ocount - 1'b1;
			idled <= idle_free;
		end
	end

	// Interrupt on entry to idle with the bus released
	assign idle_free = (state == OST_IDLE) && !bus_active;
	assign blit_int  = idle_free && !idled;

	// Request while busy or bus still held, suppressed when stopped
	assign breq_on   = ((state != OST_IDLE) || bus_active) && !stopped;
	assign blit_breq = {breq_on && cmd.bushi, breq_on && !cmd.bushi};

	always_comb begin
		stat_word             = '0;
		stat_word[STAT_IDLE]  = (state == OST_IDLE);
		stat_word[STAT_INNER] = (state == OST_INNER);
		stat_word[STAT_A1F]   = a1fupdate;
		stat_word[STAT_A1]    = a1update;
		stat_word[STAT_A2]    = a2update;
	end

	assign stat_data = stat_rd ? stat_word : '0;

	// Pointer unit expects a single update per cycle
	upd_onehot: assert property (@(posedge sys_clk) disable iff (!resetl)
		$onehot0({a1fupdate, a1update, a2update}))
		else $error("more than one update strobe");

	// A1F never ends a chain
	no_start_in_a1f: assert property (@(posedge sys_clk) disable iff (!resetl)
		!(instart && (state == OST_A1F)))
		else $error("row start during A1F update");

endmodule

`default_nettype wire

//--- blit_pkg.sv
// Shared widths, register map, command bits and FSM encoding for the blitter control
`default_nettype none

package blit_pkg;

	// Bus and field widths
	localparam int ADDR_W = 3;
	localparam int DATA_W = 32;
	localparam int CNT_W  = 16;
	localparam int PTR_W  = 24;
	localparam int STAT_W = 16;

	typedef logic [ADDR_W-1:0] reg_addr_t;
	typedef logic [DATA_W-1:0] reg_data_t;
	typedef logic [CNT_W-1:0]  cnt_t;
	typedef logic [PTR_W-1:0]  ptr_t;
	typedef logic [STAT_W-1:0] stat_t;

	// Register offsets
	localparam reg_addr_t REG_CMD      = 3'd0;
	localparam reg_addr_t REG_COUNT    = 3'd1;
	localparam reg_addr_t REG_A1_BASE  = 3'd2;
	localparam reg_addr_t REG_A1_STEP  = 3'd3;
	localparam reg_addr_t REG_A1_FSTEP = 3'd4;
	localparam reg_addr_t REG_A2_BASE  = 3'd5;
	localparam reg_addr_t REG_A2_STEP  = 3'd6;

	// Command word bit positions
	localparam int CMD_NOGO   = 7;
	localparam int CMD_UPDA1F = 8;
	localparam int CMD_UPDA1  = 9;
	localparam int CMD_UPDA2  = 10;
	localparam int CMD_BUSHI  = 29;

	// Status word bit positions, all other bits read as zero
	localparam int STAT_IDLE  = 11;
	localparam int STAT_INNER = 12;
	localparam int STAT_A1F   = 13;
	localparam int STAT_A1    = 14;
	localparam int STAT_A2    = 15;

	// Outer loop sequencer states
	typedef enum logic [2:0] {
		OST_IDLE,
		OST_INNER,
		OST_A1F,
		OST_A1,
		OST_A2
	} outer_state_t;

endpackage

`default_nettype wire

//--- blit_regs.sv
// Host write decode for the blitter: command fields, go pulse, counts, pointer bases and steps
`timescale 1ns/1ps
`default_nettype none

module blit_regs import blit_pkg::*; (
	input  wire logic      sys_clk,
	input  wire logic      resetl,
	input  wire logic      reg_wr,
	input  wire reg_addr_t reg_addr,
	input  wire reg_data_t reg_wdata,
	blit_cmd_if.regs       cmd,
	output cnt_t           outer_count,
	output cnt_t           inner_count,
	output logic           count_ld,
	output ptr_t           a1_base,
	output ptr_t           a1_step,
	output ptr_t           a1_fstep,
	output ptr_t           a2_base,
	output ptr_t           a2_step,
	output logic           a1_load,
	output logic           a2_load
);

	// Per register write enables
	logic cmd_wr;
	logic count_wr;
	logic a1_base_wr;
	logic a2_base_wr;

	assign cmd_wr     = reg_wr && (reg_addr == REG_CMD);
	assign count_wr   = reg_wr && (reg_addr == REG_COUNT);
	assign a1_base_wr = reg_wr && (reg_addr == REG_A1_BASE);
	assign a2_base_wr = reg_wr && (reg_addr == REG_A2_BASE);

	// Command bits and the strobes
	always_ff @(posedge sys_clk) begin
		if (!resetl) begin
			cmd.go     <= 1'b0;
			cmd.upda1f <= 1'b0;
			cmd.upda1  <= 1'b0;
			cmd.upda2  <= 1'b0;
			cmd.bushi  <= 1'b0;
			count_ld   <= 1'b0;
			a1_load    <= 1'b0;
			a2_load    <= 1'b0;
		end else begin
			// A command with nogo set only updates the fields
			cmd.go <= cmd_wr && !reg_wdata[CMD_NOGO];
			if (cmd_wr) begin
				cmd.upda1f <= reg_wdata[CMD_UPDA1F];
				cmd.upda1  <= reg_wdata[CMD_UPDA1];
				cmd.upda2  <= reg_wdata[CMD_UPDA2];
				cmd.bushi  <= reg_wdata[CMD_BUSHI];
			end
			count_ld <= count_wr;
			a1_load  <= a1_base_wr;
			a2_load  <= a2_base_wr;
		end
	end

	// Count and pointer value registers
	always_ff @(posedge sys_clk) begin
		if (count_wr) begin
			// Upper half is rows, lower half pixels
			outer_count <= reg_wdata[2*CNT_W-1:CNT_W];
			inner_count <= reg_wdata[CNT_W-1:0];
		end
		if (a1_base_wr)
			a1_base <= reg_wdata[PTR_W-1:0];
		if (reg_wr && (reg_addr == REG_A1_STEP))
			a1_step <= reg_wdata[PTR_W-1:0];
		if (reg_wr && (reg_addr == REG_A1_FSTEP))
			a1_fstep <= reg_wdata[PTR_W-1:0];
		if (a2_base_wr)
			a2_base <= reg_wdata[PTR_W-1:0];
		if (reg_wr && (reg_addr == REG_A2_STEP))
			a2_step <= reg_wdata[PTR_W-1:0];
	end

	// Host must space command writes so a start is a single pulse
	go_single_cycle: assert property (@(posedge sys_clk) disable iff (!resetl)
		cmd.go |=> !cmd.go)
		else $error("go held for two cycles");

endmodule

`default_nettype wire

//--- list.f
blit_pkg.sv
blit_cmd_if.sv
blit_regs.sv
blit_outer.sv
blit_inner.sv
blit_addr_update.sv
blit_ctrl_top.sv
tb_blit_ctrl.sv

//--- tb_blit_ctrl.sv
// Directed testbench for the blitter control, runs blits through register writes and checks results
`timescale 1ns/1ps
`default_nettype none

module tb_blit_ctrl import blit_pkg::*; ();

	localparam int CLK_PERIOD = 10;
	localparam int MAX_ROWS   = 6;
	localparam int MAX_PIX    = 12;
	// Worst blit is every row plus a three cycle update chain, with some slack
	localparam int BLIT_CYCLES     = MAX_ROWS * (MAX_PIX + 3) + 16;
	localparam int WATCHDOG_CYCLES = 3 + 10 + 20 + 3 * (BLIT_CYCLES + 20) + 40;

	localparam stat_t ST_IDLE_ONLY  = stat_t'(1) << STAT_IDLE;
	localparam stat_t ST_INNER_ONLY = stat_t'(1) << STAT_INNER;

	logic       sys_clk;
	logic       resetl;
	logic       reg_wr;
	reg_addr_t  reg_addr;
	reg_data_t  reg_wdata;
	logic       stat_rd;
	stat_t      stat_data;
	logic       bus_active;
	logic       stopped;
	logic [1:0] blit_breq;
	logic       blit_int;
	ptr_t       a1_ptr;
	ptr_t       a2_ptr;

	int          errors;
	int          checks;
	int          test_base;
	string       cur_test;
	logic [31:0] lcg_state;

	blit_ctrl_top DUT (
		.sys_clk(sys_clk), .resetl(resetl), .reg_wr(reg_wr), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .stat_rd(stat_rd), .stat_data(stat_data),
		.bus_active(bus_active), .stopped(stopped), .blit_breq(blit_breq),
		.blit_int(blit_int), .a1_ptr(a1_ptr), .a2_ptr(a2_ptr)
	);

	initial sys_clk = 1'b0;
	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	// Numerical Recipes LCG constants
	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Drive point is 1 ns after the rising edge
	task automatic tick();
		@(posedge sys_clk);
		#1;
	endtask

	task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		tick();
		reg_wr = 1'b0;
	endtask

	task automatic check_stat(input string what, input stat_t exp, input stat_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_ptr(input string what, input ptr_t exp, input ptr_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_breq(input string what, input logic [1:0] exp, input logic [1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_cnt(input string what, input cnt_t exp, input cnt_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("FAILED %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_base = errors;
		tick();
	endtask

	task automatic finish_test();
		$display("test %-12s %0d mismatches", cur_test, errors - test_base);
	endtask

	// Samples mid cycle until the interrupt, counting inner cycles on the status word
	task automatic wait_blit_int(input int limit, output int inner_cycles, output stat_t first_busy);
		int   n;
		logic seen_busy;
		logic done;
		n            = 0;
		inner_cycles = 0;
		seen_busy    = 1'b0;
		done         = 1'b0;
		first_busy   = '0;
		while (!done && n < limit) begin
			@(negedge sys_clk);
			n++;
			if (stat_data[STAT_INNER])
				inner_cycles++;
			if (!seen_busy && !stat_data[STAT_IDLE]) begin
				first_busy = stat_data;
				seen_busy  = 1'b1;
			end
			if (blit_int)
				done = 1'b1;
		end
		if (!done) begin
			errors++;
			$display("%s: no blit_int within %0d cycles", cur_test, limit);
		end
		tick();
	endtask

	// Count write then a command write that starts the engine
	task automatic run_blit(input cnt_t rows, input cnt_t pix, input reg_data_t cmd_word,
		output int inner_cycles, output stat_t first_busy);
		write_reg(REG_COUNT, {rows, pix});
		write_reg(REG_CMD, cmd_word);
		wait_blit_int(int'(rows) * (int'(pix) + 3) + 16, inner_cycles, first_busy);
	endtask

	// First cycle out of reset, before any clock edge can settle the interrupt history
	task automatic test_reset_state();
		cur_test  = "reset_state";
		test_base = errors;
		@(negedge sys_clk);
		// Status reads as zero while not selected
		check_stat("status unread", '0, stat_data);
		checks++;
		if (blit_int !== 1'b0) begin
			errors++;
			$display("%s: blit_int is not low after reset", cur_test);
		end
		tick();
		stat_rd = 1'b1;
		@(negedge sys_clk);
		check_stat("status", ST_IDLE_ONLY, stat_data);
		check_ptr("a1_ptr", '0, a1_ptr);
		check_ptr("a2_ptr", '0, a2_ptr);
		finish_test();
	endtask

	task automatic test_pointer_loads();
		ptr_t a1b;
		ptr_t a2b;
		start_test("ptr_loads");
		a1b = ptr_t'(next_rand());
		a2b = ptr_t'(next_rand());
		write_reg(REG_A1_BASE, reg_data_t'(a1b));
		write_reg(REG_A2_BASE, reg_data_t'(a2b));
		// Load strobe is one cycle behind the write
		tick();
		@(negedge sys_clk);
		check_ptr("a1_ptr", a1b, a1_ptr);
		check_ptr("a2_ptr", a2b, a2_ptr);
		finish_test();
	endtask

	task automatic test_single_pass();
		cnt_t  rows;
		cnt_t  pix;
		ptr_t  a1_before;
		ptr_t  a2_before;
		int    inner_cycles;
		stat_t first_busy;
		start_test("single_pass");
		rows      = cnt_t'(1 + next_rand() % MAX_ROWS);
		pix       = cnt_t'(1 + next_rand() % MAX_PIX);
		a1_before = a1_ptr;
		a2_before = a2_ptr;
		run_blit(rows, pix, '0, inner_cycles, first_busy);
		check_stat("busy status", ST_INNER_ONLY, first_busy);
		// Rows run back to back with no gap
		check_cnt("inner cycles", rows * pix, cnt_t'(inner_cycles));
		@(negedge sys_clk);
		check_stat("end status", ST_IDLE_ONLY, stat_data);
		check_ptr("a1_ptr", a1_before, a1_ptr);
		check_ptr("a2_ptr", a2_before, a2_ptr);
		finish_test();
	endtask

	// Short chain steps A1 only, full chain adds the fractional step and A2
	task automatic run_update_blit(input logic full_chain);
		cnt_t      rows;
		cnt_t      pix;
		ptr_t      a1b;
		ptr_t      a2b;
		ptr_t      step;
		ptr_t      fstep;
		ptr_t      a2step;
		ptr_t      exp_a1;
		ptr_t      exp_a2;
		reg_data_t cmd_word;
		int        inner_cycles;
		stat_t     first_busy;
		rows   = cnt_t'(2 + next_rand() % (MAX_ROWS - 1));
		pix    = cnt_t'(1 + next_rand() % MAX_PIX);
		a1b    = ptr_t'(next_rand());
		a2b    = ptr_t'(next_rand());
		step   = ptr_t'(next_rand());
		fstep  = ptr_t'(next_rand());
		a2step = ptr_t'(next_rand());
		write_reg(REG_A1_BASE, reg_data_t'(a1b));
		write_reg(REG_A2_BASE, reg_data_t'(a2b));
		write_reg(REG_A1_STEP, reg_data_t'(step));
		write_reg(REG_A1_FSTEP, reg_data_t'(fstep));
		write_reg(REG_A2_STEP, reg_data_t'(a2step));
		cmd_word = reg_data_t'(1) << CMD_UPDA1;
		if (full_chain)
			cmd_word = cmd_word | (reg_data_t'(1) << CMD_UPDA1F) | (reg_data_t'(1) << CMD_UPDA2);
		// One chain between each pair of rows, sums wrap at 24 bits
		exp_a1 = a1b;
		exp_a2 = a2b;
		for (int i = 1; i < int'(rows); i++) begin
			exp_a1 = exp_a1 + (full_chain ? fstep + step : step);
			if (full_chain)
				exp_a2 = exp_a2 + a2step;
		end
		run_blit(rows, pix, cmd_word, inner_cycles, first_busy);
		check_stat("busy status", ST_INNER_ONLY, first_busy);
		// Update cycles between rows do not count as row pixels
		check_cnt("inner cycles", rows * pix, cnt_t'(inner_cycles));
		@(negedge sys_clk);
		check_stat("end status", ST_IDLE_ONLY, stat_data);
		check_ptr("a1_ptr", exp_a1, a1_ptr);
		check_ptr("a2_ptr", exp_a2, a2_ptr);
	endtask

	task automatic test_a1_update();
		start_test("a1_update");
		run_update_blit(1'b0);
		finish_test();
	endtask

	task automatic test_full_chain();
		start_test("full_chain");
		run_update_blit(1'b1);
		finish_test();
	endtask

	task automatic test_bus_request();
		start_test("bus_request");
		write_reg(REG_CMD, (reg_data_t'(1) << CMD_NOGO) | (reg_data_t'(1) << CMD_BUSHI));
		bus_active = 1'b1;
		stopped    = 1'b0;
		// A start would show as inner by now
		tick();
		@(negedge sys_clk);
		check_stat("status after nogo", ST_IDLE_ONLY, stat_data);
		check_breq("breq high", 2'b10, blit_breq);
		tick();
		write_reg(REG_CMD, reg_data_t'(1) << CMD_NOGO);
		@(negedge sys_clk);
		check_breq("breq low", 2'b01, blit_breq);
		tick();
		stopped = 1'b1;
		@(negedge sys_clk);
		check_breq("breq stopped", 2'b00, blit_breq);
		tick();
		stopped    = 1'b0;
		bus_active = 1'b0;
		finish_test();
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		lcg_state  = 32'h962b_e12c;
		errors     = 0;
		checks     = 0;
		test_base  = 0;
		resetl     = 1'b0;
		reg_wr     = 1'b0;
		reg_addr   = '0;
		reg_wdata  = '0;
		stat_rd    = 1'b0;
		bus_active = 1'b0;
		stopped    = 1'b0;
		repeat (3) @(posedge sys_clk);
		#1;
		resetl = 1'b1;
		test_reset_state();
		test_pointer_loads();
		test_single_pass();
		test_a1_update();
		test_full_chain();
		test_bus_request();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
